/* verilog.f */
+incdir+common
+incdir+sim
common/mips_pkg.sv
src/fetch_unit.sv
decode/reg_file.sv
decode/decode_unit.sv
src/execute_unit.sv
src/mem_stage.sv
src/mips_core.sv
sim/tb_mips_core.sv

/* Makefile */
TOP := tb_mips_core

.PHONY: all lint clean

all:
	verilator --binary --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* sim/tb_asm.svh */
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// Register format, rd = rs op rt
function automatic mips_pkg::word_t r_format(input mips_pkg::funct_e fn,
                                             input mips_pkg::reg_addr_t rd,
                                             input mips_pkg::reg_addr_t rs,
                                             input mips_pkg::reg_addr_t rt);
    return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

// SLL and SRL, rd = rt shifted by sa
function automatic mips_pkg::word_t shift_format(input mips_pkg::funct_e fn,
                                                 input mips_pkg::reg_addr_t rd,
                                                 input mips_pkg::reg_addr_t rt,
                                                 input logic [4:0] sa);
    return {mips_pkg::OP_SPECIAL, 5'd0, rt, rd, sa, fn};
endfunction

// Immediate, load and store format
function automatic mips_pkg::word_t i_format(input mips_pkg::opcode_e op,
                                             input mips_pkg::reg_addr_t rt,
                                             input mips_pkg::reg_addr_t rs,
                                             input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Offset counts words from the delay slot
function automatic mips_pkg::word_t branch_format(input mips_pkg::opcode_e op,
                                                  input mips_pkg::reg_addr_t rs,
                                                  input mips_pkg::reg_addr_t rt,
                                                  input logic [15:0] offset);
    return {op, rs, rt, offset};
endfunction

`endif

/* sim/tb_mips_core.sv */
`include "mips_defines.svh"

module tb_mips_core;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_asm.svh"

    localparam int rom_words = 256;
    localparam int ram_words = 256;
    // Far above what all programs and their resets take
    localparam int timeout_cycles = 3000;

    logic             clk = 1'b0;
    logic             rst_n;
    mips_pkg::word_t  rom_data;
    mips_pkg::word_t  rom_addr;
    logic             rom_ce;
    mips_pkg::word_t  ram_rdata;
    mips_pkg::word_t  ram_addr;
    mips_pkg::word_t  ram_wdata;
    logic             ram_we;
    logic             ram_ce;

    mips_pkg::word_t  rom [rom_words];
    mips_pkg::word_t  ram [ram_words];
    mips_pkg::word_t  prog [$];
    mips_pkg::word_t  exp_addr [$];
    mips_pkg::word_t  exp_data [$];
    mips_pkg::word_t  got_addr [$];
    mips_pkg::word_t  got_data [$];
    logic [15:0]      next_store_addr;
    logic [31:0]      lfsr_state;
    int               cycle_count = 0;

    mips_core uut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .rom_data_i  (rom_data),
        .rom_addr_o  (rom_addr),
        .rom_ce_o    (rom_ce),
        .ram_rdata_i (ram_rdata),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_ce_o    (ram_ce)
    );

    always #5 clk = ~clk;

    // Both memories answer in the same cycle
    assign rom_data  = rom[rom_addr[9:2]];
    assign ram_rdata = ram[ram_addr[9:2]];

    function automatic mips_pkg::word_t fill_pattern(input int idx);
        mips_pkg::word_t addr;
        addr = mips_pkg::word_t'(idx) << 2;
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c3c_5a5a;
    endfunction

    // RAM refilled and store log cleared while reset is held
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ram_words; i++) begin
                ram[i] <= fill_pattern(i);
            end
            got_addr.delete();
            got_data.delete();
        end else if (ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
            got_addr.push_back(ram_addr);
            got_data.push_back(ram_wdata);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not complete within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic mips_pkg::word_t random_word(input int nbits);
        mips_pkg::word_t value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    task automatic check_word(input mips_pkg::word_t got, input mips_pkg::word_t expected,
                              input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, what, got, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at first failed check");
        end
    endtask

    task automatic check_bit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s: got %b, expected %b", $time, what, got, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at first failed check");
        end
    endtask

    task automatic new_program(input logic [15:0] store_base);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        next_store_addr = store_base;
    endtask

    task automatic load_constant(input mips_pkg::reg_addr_t r, input mips_pkg::word_t value);
        prog.push_back(i_format(mips_pkg::OP_LUI, r, 0, value[31:16]));
        prog.push_back(i_format(mips_pkg::OP_ORI, r, r, value[15:0]));
    endtask

    // SW to the next free slot with its expected data recorded
    task automatic emit_store(input mips_pkg::reg_addr_t rt, input mips_pkg::word_t value);
        prog.push_back(i_format(mips_pkg::OP_SW, rt, 0, next_store_addr));
        exp_addr.push_back({16'h0000, next_store_addr});
        exp_data.push_back(value);
        next_store_addr = next_store_addr + 16'd4;
    endtask

    task automatic check_reset_outputs();
        check_bit(rom_ce, 1'b0, "rom_ce_o during reset");
        check_bit(ram_ce, 1'b0, "ram_ce_o during reset");
        check_bit(ram_we, 1'b0, "ram_we_o during reset");
        check_word(rom_addr, `MIPS_RESET_PC, "fetch address during reset");
    endtask

    // Program ends in a branch to itself with a no-op delay slot
    task automatic start_program();
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = `MIPS_NOP;
        end
        foreach (prog[i]) begin
            rom[i] = prog[i];
        end
        rom[prog.size()] = branch_format(mips_pkg::OP_BEQ, 0, 0, 16'hffff);
        check_reset_outputs();
        repeat (4) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic compare_stores(input string name);
        while (got_addr.size() < exp_addr.size()) begin
            @(negedge clk);
        end
        foreach (exp_addr[i]) begin
            check_word(got_addr[i], exp_addr[i], $sformatf("%s store %0d address", name, i));
            check_word(got_data[i], exp_data[i], $sformatf("%s store %0d data", name, i));
        end
    endtask

    task automatic test_reset_and_fetch();
        int count;
        new_program(16'h0000);
        repeat (8) begin
            prog.push_back(`MIPS_NOP);
        end
        start_program();
        count = 0;
        while (count < 6) begin
            @(negedge clk);
            if (rom_ce) begin
                check_word(rom_addr, `MIPS_RESET_PC + mips_pkg::word_t'(4 * count),
                           $sformatf("fetch address %0d", count));
                count++;
            end
        end
    endtask

    task automatic test_alu_chain();
        mips_pkg::word_t a, b, sa1, sa2, imm1, imm2;
        mips_pkg::word_t r3, r4, r5, r6, r7, r8, r9, r10, r11, r12, r13;
        a    = random_word(32);
        b    = random_word(32);
        sa1  = random_word(5);
        sa2  = random_word(5);
        imm1 = random_word(16);
        imm2 = random_word(16);
        new_program(16'h0100);
        load_constant(1, a);
        load_constant(2, b);
        // Each source comes from execute, memory or writeback in turn
        prog.push_back(r_format(mips_pkg::FN_ADDU, 3, 1, 2));
        r3 = a + b;
        prog.push_back(r_format(mips_pkg::FN_SUBU, 4, 3, 1));
        r4 = r3 - a;
        prog.push_back(r_format(mips_pkg::FN_AND, 5, 4, 3));
        r5 = r4 & r3;
        prog.push_back(r_format(mips_pkg::FN_OR, 6, 5, 3));
        r6 = r5 | r3;
        prog.push_back(r_format(mips_pkg::FN_XOR, 7, 6, 2));
        r7 = r6 ^ b;
        prog.push_back(r_format(mips_pkg::FN_SLT, 8, 7, 1));
        r8 = ($signed(r7) < $signed(a)) ? 32'd1 : 32'd0;
        prog.push_back(shift_format(mips_pkg::FN_SLL, 9, 7, sa1[4:0]));
        r9 = r7 << sa1[4:0];
        prog.push_back(shift_format(mips_pkg::FN_SRL, 10, 9, sa2[4:0]));
        r10 = r9 >> sa2[4:0];
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 11, 10, imm1[15:0]));
        r11 = r10 + {{16{imm1[15]}}, imm1[15:0]};
        prog.push_back(i_format(mips_pkg::OP_ANDI, 12, 11, imm2[15:0]));
        r12 = r11 & {16'h0000, imm2[15:0]};
        prog.push_back(r_format(mips_pkg::FN_ADDU, 13, 12, 11));
        r13 = r12 + r11;
        emit_store(3, r3);
        emit_store(4, r4);
        emit_store(5, r5);
        emit_store(6, r6);
        emit_store(7, r7);
        emit_store(8, r8);
        emit_store(9, r9);
        emit_store(10, r10);
        emit_store(11, r11);
        emit_store(12, r12);
        emit_store(13, r13);
        start_program();
        compare_stores("alu chain");
    endtask

    task automatic test_load_use();
        mips_pkg::word_t x, y;
        x = random_word(32);
        y = random_word(32);
        new_program(16'h0200);
        load_constant(1, x);
        load_constant(2, y);
        emit_store(1, x);
        prog.push_back(i_format(mips_pkg::OP_LW, 3, 0, 16'h0200));
        prog.push_back(r_format(mips_pkg::FN_ADDU, 4, 3, 2));
        emit_store(4, x + y);
        // Loaded value used directly as store data
        prog.push_back(i_format(mips_pkg::OP_LW, 5, 0, 16'h0204));
        emit_store(5, x + y);
        start_program();
        compare_stores("load use");
    endtask

    task automatic test_branches();
        mips_pkg::word_t v;
        v = random_word(15);
        new_program(16'h0300);
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 3, 0, 16'h00aa));
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 4, 0, 16'h00bb));
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 1, 0, v[15:0]));
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 2, 0, v[15:0]));
        prog.push_back(branch_format(mips_pkg::OP_BEQ, 1, 2, 16'd2));
        emit_store(3, 32'h0000_00aa);
        // Skipped by the taken BEQ
        prog.push_back(i_format(mips_pkg::OP_SW, 4, 0, 16'h03f0));
        prog.push_back(branch_format(mips_pkg::OP_BNE, 1, 2, 16'd2));
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 5, 0, 16'h00cc));
        emit_store(5, 32'h0000_00cc);
        emit_store(1, v);
        start_program();
        compare_stores("branches");
    endtask

    task automatic test_zero_register();
        mips_pkg::word_t imm;
        imm = random_word(16) | 32'd1;
        new_program(16'h0400);
        prog.push_back(i_format(mips_pkg::OP_ADDIU, 0, 0, imm[15:0]));
        emit_store(0, 32'h0000_0000);
        repeat (3) begin
            prog.push_back(`MIPS_NOP);
        end
        emit_store(0, 32'h0000_0000);
        start_program();
        compare_stores("zero register");
    endtask

    initial begin
        rst_n      = 1'b0;
        lfsr_state = 32'hec6c;
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = `MIPS_NOP;
        end
        test_reset_and_fetch();
        test_alu_chain();
        test_load_use();
        test_branches();
        test_zero_register();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* src/mips_core.sv */
module mips_core (
    input  logic             clk,
    input  logic             rst_n_i,
    input  mips_pkg::word_t  rom_data_i,
    output mips_pkg::word_t  rom_addr_o,
    output logic             rom_ce_o,
    input  mips_pkg::word_t  ram_rdata_i,
    output mips_pkg::word_t  ram_addr_o,
    output mips_pkg::word_t  ram_wdata_o,
    output logic             ram_we_o,
    output logic             ram_ce_o
);

    // Fetch to decode
    mips_pkg::word_t      id_pc;
    mips_pkg::word_t      id_inst;

    // Decode back to fetch
    logic                 stall;
    logic                 branch_taken;
    mips_pkg::word_t      branch_target;

    // Decode to execute
    mips_pkg::alu_op_e    id_alu_op;
    mips_pkg::word_t      id_operand_a;
    mips_pkg::word_t      id_operand_b;
    mips_pkg::word_t      id_store_data;
    logic                 id_is_load;
    logic                 id_is_store;
    logic                 id_wr_en;
    mips_pkg::reg_addr_t  id_wr_addr;

    // Execute to memory, also forwarded
    mips_pkg::word_t      ex_result;
    mips_pkg::word_t      ex_store_data;
    logic                 ex_is_load;
    logic                 ex_is_store;
    logic                 ex_wr_en;
    mips_pkg::reg_addr_t  ex_wr_addr;

    // Memory and writeback results
    logic                 mem_wr_en;
    mips_pkg::reg_addr_t  mem_wr_addr;
    mips_pkg::word_t      mem_result;
    logic                 wb_wr_en;
    mips_pkg::reg_addr_t  wb_wr_addr;
    mips_pkg::word_t      wb_wr_data;

    fetch_unit u_fetch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .rom_data_i      (rom_data_i),
        .rom_addr_o      (rom_addr_o),
        .rom_ce_o        (rom_ce_o),
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst)
    );

    decode_unit u_decode (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .id_pc_i         (id_pc),
        .id_inst_i       (id_inst),
        .ex_wr_en_i      (ex_wr_en),
        .ex_wr_addr_i    (ex_wr_addr),
        .ex_result_i     (ex_result),
        .ex_is_load_i    (ex_is_load),
        .mem_wr_en_i     (mem_wr_en),
        .mem_wr_addr_i   (mem_wr_addr),
        .mem_result_i    (mem_result),
        .wb_wr_en_i      (wb_wr_en),
        .wb_wr_addr_i    (wb_wr_addr),
        .wb_wr_data_i    (wb_wr_data),
        .stall_o         (stall),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .alu_op_o        (id_alu_op),
        .operand_a_o     (id_operand_a),
        .operand_b_o     (id_operand_b),
        .store_data_o    (id_store_data),
        .is_load_o       (id_is_load),
        .is_store_o      (id_is_store),
        .wr_en_o         (id_wr_en),
        .wr_addr_o       (id_wr_addr)
    );

    execute_unit u_execute (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall),
        .alu_op_i        (id_alu_op),
        .operand_a_i     (id_operand_a),
        .operand_b_i     (id_operand_b),
        .store_data_i    (id_store_data),
        .is_load_i       (id_is_load),
        .is_store_i      (id_is_store),
        .wr_en_i         (id_wr_en),
        .wr_addr_i       (id_wr_addr),
        .ex_result_o     (ex_result),
        .ex_store_data_o (ex_store_data),
        .ex_is_load_o    (ex_is_load),
        .ex_is_store_o   (ex_is_store),
        .ex_wr_en_o      (ex_wr_en),
        .ex_wr_addr_o    (ex_wr_addr)
    );

    mem_stage u_mem (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_result_i     (ex_result),
        .ex_store_data_i (ex_store_data),
        .ex_is_load_i    (ex_is_load),
        .ex_is_store_i   (ex_is_store),
        .ex_wr_en_i      (ex_wr_en),
        .ex_wr_addr_i    (ex_wr_addr),
        .ram_rdata_i     (ram_rdata_i),
        .ram_addr_o      (ram_addr_o),
        .ram_wdata_o     (ram_wdata_o),
        .ram_we_o        (ram_we_o),
        .ram_ce_o        (ram_ce_o),
        .mem_wr_en_o     (mem_wr_en),
        .mem_wr_addr_o   (mem_wr_addr),
        .mem_result_o    (mem_result),
        .wb_wr_en_o      (wb_wr_en),
        .wb_wr_addr_o    (wb_wr_addr),
        .wb_wr_data_o    (wb_wr_data)
    );

endmodule

/* src/mem_stage.sv */
module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  mips_pkg::word_t      ex_result_i,
    input  mips_pkg::word_t      ex_store_data_i,
    input  logic                 ex_is_load_i,
    input  logic                 ex_is_store_i,
    input  logic                 ex_wr_en_i,
    input  mips_pkg::reg_addr_t  ex_wr_addr_i,
    input  mips_pkg::word_t      ram_rdata_i,
    output mips_pkg::word_t      ram_addr_o,
    output mips_pkg::word_t      ram_wdata_o,
    output logic                 ram_we_o,
    output logic                 ram_ce_o,
    output logic                 mem_wr_en_o,
    output mips_pkg::reg_addr_t  mem_wr_addr_o,
    output mips_pkg::word_t      mem_result_o,
    output logic                 wb_wr_en_o,
    output mips_pkg::reg_addr_t  wb_wr_addr_o,
    output mips_pkg::word_t      wb_wr_data_o
);

    logic m_is_load;

    // Execute to memory
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_is_load   <= 1'b0;
            ram_we_o    <= 1'b0;
            mem_wr_en_o <= 1'b0;
        end else begin
            m_is_load   <= ex_is_load_i;
            ram_we_o    <= ex_is_store_i;
            mem_wr_en_o <= ex_wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        ram_addr_o    <= ex_result_i;
        ram_wdata_o   <= ex_store_data_i;
        mem_wr_addr_o <= ex_wr_addr_i;
    end

    assign ram_ce_o     = m_is_load || ram_we_o;
    assign mem_result_o = m_is_load ? ram_rdata_i : ram_addr_o;

    // Memory to writeback
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_wr_en_o <= 1'b0;
        end else begin
            wb_wr_en_o <= mem_wr_en_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_wr_addr_o <= mem_wr_addr_o;
        wb_wr_data_o <= mem_result_o;
    end

    // One RAM access per cycle
    a_load_store_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(m_is_load && ram_we_o))
        else $error("load and store in the memory stage at once");

    // Word access only
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_ce_o |-> ram_addr_o[1:0] == 2'b00)
        else $error("unaligned RAM address %h", ram_addr_o);

endmodule

/* src/execute_unit.sv */
`include "mips_defines.svh"

module execute_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  mips_pkg::alu_op_e    alu_op_i,
    input  mips_pkg::word_t      operand_a_i,
    input  mips_pkg::word_t      operand_b_i,
    input  mips_pkg::word_t      store_data_i,
    input  logic                 is_load_i,
    input  logic                 is_store_i,
    input  logic                 wr_en_i,
    input  mips_pkg::reg_addr_t  wr_addr_i,
    output mips_pkg::word_t      ex_result_o,
    output mips_pkg::word_t      ex_store_data_o,
    output logic                 ex_is_load_o,
    output logic                 ex_is_store_o,
    output logic                 ex_wr_en_o,
    output mips_pkg::reg_addr_t  ex_wr_addr_o
);

    mips_pkg::alu_op_e  alu_op;
    mips_pkg::word_t    op_a;
    mips_pkg::word_t    op_b;

    // Control bits, cleared to a bubble on stall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_is_load_o  <= 1'b0;
            ex_is_store_o <= 1'b0;
            ex_wr_en_o    <= 1'b0;
        end else if (stall_i) begin
            ex_is_load_o  <= 1'b0;
            ex_is_store_o <= 1'b0;
            ex_wr_en_o    <= 1'b0;
        end else begin
            ex_is_load_o  <= is_load_i;
            ex_is_store_o <= is_store_i;
            ex_wr_en_o    <= wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_op          <= alu_op_i;
        op_a            <= operand_a_i;
        op_b            <= operand_b_i;
        ex_store_data_o <= store_data_i;
        ex_wr_addr_o    <= wr_addr_i;
    end

    // Also forms the load/store address
    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD:    ex_result_o = op_a + op_b;
            mips_pkg::ALU_SUB:    ex_result_o = op_a - op_b;
            mips_pkg::ALU_AND:    ex_result_o = op_a & op_b;
            mips_pkg::ALU_OR:     ex_result_o = op_a | op_b;
            mips_pkg::ALU_XOR:    ex_result_o = op_a ^ op_b;
            mips_pkg::ALU_SLT: begin
                ex_result_o = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            mips_pkg::ALU_SLL:    ex_result_o = op_b << op_a[4:0];
            mips_pkg::ALU_SRL:    ex_result_o = op_b >> op_a[4:0];
            mips_pkg::ALU_PASS_B: ex_result_o = op_b;
            default:              ex_result_o = op_a + op_b;
        endcase
    end

endmodule

/* decode/decode_unit.sv */
`include "mips_defines.svh"

module decode_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  mips_pkg::word_t      id_pc_i,
    input  mips_pkg::word_t      id_inst_i,
    input  logic                 ex_wr_en_i,
    input  mips_pkg::reg_addr_t  ex_wr_addr_i,
    input  mips_pkg::word_t      ex_result_i,
    input  logic                 ex_is_load_i,
    input  logic                 mem_wr_en_i,
    input  mips_pkg::reg_addr_t  mem_wr_addr_i,
    input  mips_pkg::word_t      mem_result_i,
    input  logic                 wb_wr_en_i,
    input  mips_pkg::reg_addr_t  wb_wr_addr_i,
    input  mips_pkg::word_t      wb_wr_data_i,
    output logic                 stall_o,
    output logic                 branch_taken_o,
    output mips_pkg::word_t      branch_target_o,
    output mips_pkg::alu_op_e    alu_op_o,
    output mips_pkg::word_t      operand_a_o,
    output mips_pkg::word_t      operand_b_o,
    output mips_pkg::word_t      store_data_o,
    output logic                 is_load_o,
    output logic                 is_store_o,
    output logic                 wr_en_o,
    output mips_pkg::reg_addr_t  wr_addr_o
);

    mips_pkg::opcode_e    opcode;
    mips_pkg::funct_e     funct;
    mips_pkg::reg_addr_t  rs;
    mips_pkg::reg_addr_t  rt;
    mips_pkg::reg_addr_t  rd;
    mips_pkg::word_t      imm_sext;
    mips_pkg::word_t      imm_zext;
    mips_pkg::word_t      shamt;
    mips_pkg::word_t      rf_data_a;
    mips_pkg::word_t      rf_data_b;
    mips_pkg::word_t      rs_val;
    mips_pkg::word_t      rt_val;
    mips_pkg::reg_addr_t  wr_dest;
    logic                 writes;
    logic                 use_rs;
    logic                 use_rt;
    logic                 is_beq;
    logic                 is_bne;

    assign opcode   = mips_pkg::opcode_e'(id_inst_i[31:26]);
    assign funct    = mips_pkg::funct_e'(id_inst_i[5:0]);
    assign rs       = id_inst_i[25:21];
    assign rt       = id_inst_i[20:16];
    assign rd       = id_inst_i[15:11];
    assign imm_sext = {{(`MIPS_XLEN-16){id_inst_i[15]}}, id_inst_i[15:0]};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, id_inst_i[15:0]};
    assign shamt    = {{(`MIPS_XLEN-5){1'b0}}, id_inst_i[10:6]};

    reg_file u_reg_file (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (rs),
        .rd_addr_b_i (rt),
        .wr_en_i     (wb_wr_en_i),
        .wr_addr_i   (wb_wr_addr_i),
        .wr_data_i   (wb_wr_data_i),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b)
    );

    // Youngest producer wins
    assign rs_val = (ex_wr_en_i && ex_wr_addr_i == rs)   ? ex_result_i  :
                    (mem_wr_en_i && mem_wr_addr_i == rs) ? mem_result_i : rf_data_a;
    assign rt_val = (ex_wr_en_i && ex_wr_addr_i == rt)   ? ex_result_i  :
                    (mem_wr_en_i && mem_wr_addr_i == rt) ? mem_result_i : rf_data_b;

    always_comb begin
        alu_op_o    = mips_pkg::ALU_ADD;
        operand_a_o = rs_val;
        operand_b_o = imm_sext;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        wr_dest     = rt;
        writes      = 1'b0;
        use_rs      = 1'b1;
        use_rt      = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                operand_b_o = rt_val;
                wr_dest     = rd;
                writes      = 1'b1;
                use_rt      = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op_o = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op_o = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op_o = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op_o = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op_o = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op_o = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL: begin
                        // Shift amount rides in operand A
                        alu_op_o    = (funct == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL
                                                                   : mips_pkg::ALU_SRL;
                        operand_a_o = shamt;
                        use_rs      = 1'b0;
                    end
                    default: writes = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: writes = 1'b1;
            mips_pkg::OP_ANDI: begin
                alu_op_o    = mips_pkg::ALU_AND;
                operand_b_o = imm_zext;
                writes      = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op_o    = mips_pkg::ALU_OR;
                operand_b_o = imm_zext;
                writes      = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op_o    = mips_pkg::ALU_PASS_B;
                operand_b_o = {id_inst_i[15:0], 16'h0000};
                writes      = 1'b1;
                use_rs      = 1'b0;
            end
            mips_pkg::OP_LW: begin
                is_load_o = 1'b1;
                writes    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                is_store_o = 1'b1;
                use_rt     = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                is_beq = 1'b1;
                use_rt = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                is_bne = 1'b1;
                use_rt = 1'b1;
            end
            default: use_rs = 1'b0;
        endcase
    end

    assign store_data_o = rt_val;
    assign wr_addr_o    = wr_dest;
    assign wr_en_o      = writes && (wr_dest != '0);

    // Load result not ready until the load reaches memory
    assign stall_o = ex_is_load_i && ex_wr_en_i &&
                     ((use_rs && ex_wr_addr_i == rs) || (use_rt && ex_wr_addr_i == rt));

    // Target relative to the delay slot
    assign branch_target_o = id_pc_i + mips_pkg::word_t'(4) + {imm_sext[`MIPS_XLEN-3:0], 2'b00};
    assign branch_taken_o  = !stall_o &&
                             ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val));

    // A stall puts a bubble behind the load, which cannot trigger another
    a_single_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !stall_o)
        else $error("load-use stall held for two consecutive cycles");

endmodule

/* decode/reg_file.sv */
`include "mips_defines.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  mips_pkg::reg_addr_t  rd_addr_a_i,
    input  mips_pkg::reg_addr_t  rd_addr_b_i,
    input  logic                 wr_en_i,
    input  mips_pkg::reg_addr_t  wr_addr_i,
    input  mips_pkg::word_t      wr_data_i,
    output mips_pkg::word_t      rd_data_a_o,
    output mips_pkg::word_t      rd_data_b_o
);

    mips_pkg::word_t regs [1:`MIPS_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Write-through so writeback needs no forwarding path of its own
    always_comb begin
        if (rd_addr_a_i == '0) begin
            rd_data_a_o = '0;
        end else if (wr_en_i && wr_addr_i == rd_addr_a_i) begin
            rd_data_a_o = wr_data_i;
        end else begin
            rd_data_a_o = regs[rd_addr_a_i];
        end
    end

    always_comb begin
        if (rd_addr_b_i == '0) begin
            rd_data_b_o = '0;
        end else if (wr_en_i && wr_addr_i == rd_addr_b_i) begin
            rd_data_b_o = wr_data_i;
        end else begin
            rd_data_b_o = regs[rd_addr_b_i];
        end
    end

    // Written value reads back on the next cycle unless overwritten
    a_write_reads_back: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr_en_i && wr_addr_i != '0) |=>
            (rd_addr_a_i != $past(wr_addr_i) ||
             (wr_en_i && wr_addr_i == rd_addr_a_i) ||
             rd_data_a_o == $past(wr_data_i)))
        else $error("register file lost a write");

endmodule

/* src/fetch_unit.sv */
`include "mips_defines.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              branch_taken_i,
    input  mips_pkg::word_t   branch_target_i,
    input  mips_pkg::word_t   rom_data_i,
    output mips_pkg::word_t   rom_addr_o,
    output logic              rom_ce_o,
    output mips_pkg::word_t   id_pc_o,
    output mips_pkg::word_t   id_inst_o
);

    mips_pkg::word_t pc;

    assign rom_addr_o = pc;

    // ROM enable rises one cycle after reset, PC starts moving once it is up
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rom_ce_o  <= 1'b0;
            pc        <= `MIPS_RESET_PC;
            id_pc_o   <= `MIPS_RESET_PC;
            id_inst_o <= `MIPS_NOP;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i) begin
                // Instruction fetched now is the delay slot of a taken branch
                if (branch_taken_i) begin
                    pc <= branch_target_i;
                end else begin
                    pc <= pc + mips_pkg::word_t'(4);
                end
                id_pc_o   <= pc;
                id_inst_o <= rom_data_i;
            end
        end
    end

endmodule

/* common/mips_pkg.sv */
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* common/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and address width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// SLL r0, r0, 0
`define MIPS_NOP 32'h0000_0000

`endif
